// File: src/conv_pkg.sv
package conv_pkg;

  // engine geometry.
  localparam int CORES     = 4;   // output channels.
  localparam int UNITS     = 2;   // pixels per beat.

  // datapath widths.
  localparam int WORD_IN   = 8;   // pixel and weight.
  localparam int WORD_PROD = 16;  // full signed product.
  localparam int WORD_SUM  = 20;  // accumulator.
  localparam int USER_W    = 4;   // tag carried with the last beat.

  // 16 full-scale products of 2**14 reach 2**18, inside a signed 20 bit sum.
  localparam int MAX_BEATS = 16;

  // multiplier depth, join register included.
  localparam int MUL_DELAY = 3;

  typedef logic signed [WORD_IN-1:0]   pixel_t;
  typedef logic signed [WORD_IN-1:0]   weight_t;
  typedef logic signed [WORD_PROD-1:0] product_t;
  typedef logic signed [WORD_SUM-1:0]  sum_t;
  typedef logic        [USER_W-1:0]    user_t;

  // one pixel beat, last marks the end of a packet.
  typedef struct packed {
    pixel_t [UNITS-1:0] pixels;
    logic               last;
    user_t              user;
  } pix_beat_t;

  // one weight beat, a weight per core.
  typedef struct packed {
    weight_t [CORES-1:0] weights;
  } wt_beat_t;

  // pixel and weight beats taken in the same cycle.
  typedef struct packed {
    logic                valid;
    logic                last;
    user_t               user;
    pixel_t  [UNITS-1:0] pixels;
    weight_t [CORES-1:0] weights;
  } join_beat_t;

  // every core by unit product with its tags.
  typedef struct packed {
    logic                                 valid;
    logic                                 last;
    user_t                                user;
    product_t [CORES-1:0][UNITS-1:0]      products;
  } prod_beat_t;

  // finished sums of one packet.
  typedef struct packed {
    sum_t [CORES-1:0][UNITS-1:0] sums;
  } result_t;

endpackage

// File: src/beat_join.sv
`timescale 1ns/100ps

module beat_join (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 clken,           // downstream ready, freezes all.
  input  logic                 s_pixels_valid,
  input  conv_pkg::pix_beat_t  s_pixels,
  output logic                 s_pixels_ready,
  input  logic                 s_weights_valid,
  input  conv_pkg::wt_beat_t   s_weights,
  output logic                 s_weights_ready,
  output conv_pkg::join_beat_t beat             // registered pair.
);

  logic                                    valid_q;    // pair taken last enabled cycle.
  logic                                    last_q;     // end of packet.
  conv_pkg::user_t                         user_q;     // tag of the pixel beat.
  conv_pkg::pixel_t  [conv_pkg::UNITS-1:0] pixels_q;
  conv_pkg::weight_t [conv_pkg::CORES-1:0] weights_q;

  // each side waits for the other.
  // a lone pixel or weight beat is never taken.
  assign s_pixels_ready  = clken & s_weights_valid;
  assign s_weights_ready = clken & s_pixels_valid;

  // valid marks a real transfer.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (clken) begin
      valid_q <= s_pixels_valid & s_weights_valid;  // both handshakes fire together.
    end
  end

  // payload follows every enabled edge.
  always_ff @(posedge clk) begin
    if (clken) begin
      last_q    <= s_pixels.last;
      user_q    <= s_pixels.user;
      pixels_q  <= s_pixels.pixels;
      weights_q <= s_weights.weights;
    end
  end

  // pack the pair for the multipliers.
  assign beat = '{
    valid:   valid_q,
    last:    last_q,
    user:    user_q,
    pixels:  pixels_q,
    weights: weights_q
  };

endmodule

// File: src/mul_array.sv
`timescale 1ns/100ps

module mul_array (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 clken,  // stalls the whole pipe.
  input  conv_pkg::join_beat_t beat,   // joined pixels and weights.
  output conv_pkg::prod_beat_t prod    // products, MUL_DELAY after acceptance.
);

  // products of the beat at the input, ahead of the first register.
  conv_pkg::product_t [conv_pkg::CORES-1:0][conv_pkg::UNITS-1:0] mul_now;

  // product registers, stage 0 first.
  conv_pkg::product_t [conv_pkg::CORES-1:0][conv_pkg::UNITS-1:0]
    mul_pipe [conv_pkg::MUL_DELAY-2:0];

  // tags travel beside the products.
  logic [conv_pkg::MUL_DELAY-2:0]            valid_pipe;
  logic [conv_pkg::MUL_DELAY-2:0]            last_pipe;
  conv_pkg::user_t [conv_pkg::MUL_DELAY-2:0] user_pipe;

  // signed multiply, every core against every unit.
  always_comb begin
    for (int c = 0; c < conv_pkg::CORES; c++) begin
      for (int u = 0; u < conv_pkg::UNITS; u++) begin
        if (beat.valid) begin
          mul_now[c][u] = conv_pkg::pixel_t'(beat.pixels[u])
                        * conv_pkg::weight_t'(beat.weights[c]);
        end else begin
          mul_now[c][u] = '0;  // idle slots carry zero.
        end
      end
    end
  end

  // valid pipe, the only state cleared by reset.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_pipe <= '0;
    end else if (clken) begin
      valid_pipe[0] <= beat.valid;
      for (int s = 1; s < conv_pkg::MUL_DELAY - 1; s++) begin
        valid_pipe[s] <= valid_pipe[s-1];
      end
    end
  end

  // product and tag registers.
  always_ff @(posedge clk) begin
    if (clken) begin
      mul_pipe[0]  <= mul_now;      // first stage holds the raw products.
      last_pipe[0] <= beat.last;
      user_pipe[0] <= beat.user;
      // later stages only retime.
      for (int s = 1; s < conv_pkg::MUL_DELAY - 1; s++) begin
        mul_pipe[s]  <= mul_pipe[s-1];
        last_pipe[s] <= last_pipe[s-1];
        user_pipe[s] <= user_pipe[s-1];
      end
    end
  end

  // last stage feeds the accumulators.
  always_comb begin
    prod.valid    = valid_pipe[conv_pkg::MUL_DELAY-2];
    prod.last     = last_pipe[conv_pkg::MUL_DELAY-2];
    prod.user     = user_pipe[conv_pkg::MUL_DELAY-2];
    prod.products = mul_pipe[conv_pkg::MUL_DELAY-2];
  end

endmodule

// File: src/acc_array.sv
`timescale 1ns/100ps

module acc_array (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 clken,    // downstream ready.
  input  conv_pkg::prod_beat_t prod,     // products from the multipliers.
  output logic                 m_valid,  // one enabled cycle per packet.
  output conv_pkg::result_t    m_data,   // sums of the finished packet.
  output conv_pkg::user_t      m_user    // tag of its last beat.
);

  conv_pkg::sum_t [conv_pkg::CORES-1:0][conv_pkg::UNITS-1:0] acc_q;     // running sums.
  conv_pkg::sum_t [conv_pkg::CORES-1:0][conv_pkg::UNITS-1:0] acc_next;  // sums after this beat.

  logic first_q;   // next valid beat opens a packet.
  logic pkt_done;  // valid last product at the input.

  assign pkt_done = prod.valid & prod.last;

  // load on the first beat, add afterwards.
  // this clears the old packet without a separate clear cycle.
  always_comb begin
    for (int c = 0; c < conv_pkg::CORES; c++) begin
      for (int u = 0; u < conv_pkg::UNITS; u++) begin
        if (first_q) begin
          acc_next[c][u] = conv_pkg::sum_t'(prod.products[c][u]);
        end else begin
          acc_next[c][u] = acc_q[c][u] + conv_pkg::sum_t'(prod.products[c][u]);
        end
      end
    end
  end

  // packet boundary tracking and the output valid.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      first_q <= 1'b1;  // first packet starts clean.
      m_valid <= 1'b0;
    end else if (clken) begin
      m_valid <= pkt_done;  // drops again on the following enabled edge.
      if (prod.valid) begin
        first_q <= prod.last;  // a last beat arms the next clear.
      end
    end
  end

  // accumulators step only on valid products.
  always_ff @(posedge clk) begin
    if (clken && prod.valid) begin
      acc_q <= acc_next;
    end
  end

  // result register.
  // catches the new sums on the same edge as the accumulators.
  always_ff @(posedge clk) begin
    if (clken && pkt_done) begin
      m_data.sums <= acc_next;
      m_user      <= prod.user;  // tag rides with the last beat.
    end
  end

endmodule

// File: src/conv_engine.sv
`timescale 1ns/100ps

module conv_engine (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                clken,            // downstream ready, global enable.
  // pixel stream.
  input  logic                s_pixels_valid,
  input  conv_pkg::pix_beat_t s_pixels,
  output logic                s_pixels_ready,
  // weight stream.
  input  logic                s_weights_valid,
  input  conv_pkg::wt_beat_t  s_weights,
  output logic                s_weights_ready,
  // result.
  output logic                m_valid,
  output conv_pkg::result_t   m_data,
  output conv_pkg::user_t     m_user
);

  conv_pkg::join_beat_t join_beat;  // join to multipliers.
  conv_pkg::prod_beat_t prod_beat;  // multipliers to accumulators.

  // pairs a pixel beat with a weight beat.
  beat_join u_join (
    .clk             (clk),
    .rst_n           (rst_n),
    .clken           (clken),
    .s_pixels_valid  (s_pixels_valid),
    .s_pixels        (s_pixels),
    .s_pixels_ready  (s_pixels_ready),
    .s_weights_valid (s_weights_valid),
    .s_weights       (s_weights),
    .s_weights_ready (s_weights_ready),
    .beat            (join_beat)
  );

  // cores x units products, tags kept aligned.
  mul_array u_mul (
    .clk   (clk),
    .rst_n (rst_n),
    .clken (clken),
    .beat  (join_beat),
    .prod  (prod_beat)
  );

  // sums over the beats of a packet.
  // the result leaves one enabled cycle after the last product.
  acc_array u_acc (
    .clk     (clk),
    .rst_n   (rst_n),
    .clken   (clken),
    .prod    (prod_beat),
    .m_valid (m_valid),
    .m_data  (m_data),
    .m_user  (m_user)
  );

endmodule

// File: sim/conv_model.svh
`ifndef CONV_MODEL_SVH
`define CONV_MODEL_SVH

// running sums of the open packet, kept as plain ints.
int model_sum [conv_pkg::CORES][conv_pkg::UNITS];

// a new packet starts from zero.
function automatic void clear_sums();
  for (int c = 0; c < conv_pkg::CORES; c++) begin
    for (int u = 0; u < conv_pkg::UNITS; u++) begin
      model_sum[c][u] = 0;
    end
  end
endfunction

// one accepted pair, every pixel against every core weight.
function automatic void add_products(input conv_pkg::pix_beat_t pix,
                                     input conv_pkg::wt_beat_t  wt);
  int p;
  int w;
  for (int c = 0; c < conv_pkg::CORES; c++) begin
    for (int u = 0; u < conv_pkg::UNITS; u++) begin
      p = $signed(pix.pixels[u]);  // sign extended to 32 bits.
      w = $signed(wt.weights[c]);
      model_sum[c][u] += p * w;
    end
  end
endfunction

// expected result word for the closed packet.
function automatic conv_pkg::result_t pack_sums();
  conv_pkg::result_t r;
  for (int c = 0; c < conv_pkg::CORES; c++) begin
    for (int u = 0; u < conv_pkg::UNITS; u++) begin
      r.sums[c][u] = conv_pkg::sum_t'(model_sum[c][u]);
    end
  end
  return r;
endfunction

// a side is ready when the engine runs and the other side offers a beat.
function automatic logic join_ready(input logic enable, input logic other_valid);
  return enable & other_valid;
endfunction

`endif

// File: sim/tb_conv_engine.sv
`timescale 1ns/100ps

module tb_conv_engine;

  localparam int NUM_PKTS    = 200;
  localparam int HIGH_PKTS   = 50;   // clken held high for these.
  localparam int SINGLE_FROM = 150;  // single beat packets from here on.
  localparam int RESULT_LAT  = 4;    // enabled cycles, accept edge to transfer edge.
  localparam int TIMEOUT_CYCLES = NUM_PKTS * conv_pkg::MAX_BEATS * 4 + 200;

  logic                clk;
  logic                rst_n;
  logic                clken;
  logic                s_pixels_valid;
  conv_pkg::pix_beat_t s_pixels;
  logic                s_pixels_ready;
  logic                s_weights_valid;
  conv_pkg::wt_beat_t  s_weights;
  logic                s_weights_ready;
  logic                m_valid;
  conv_pkg::result_t   m_data;
  conv_pkg::user_t     m_user;

  int seed       = 59568;
  int cycle_cnt  = 0;
  int en_cnt     = 0;  // enabled edges since reset.
  int pkt_idx    = 0;
  int beat_idx   = 0;
  int pkt_len    = 1;
  int stall_left = 0;
  int results    = 0;
  int value_errs = 0;
  int other_errs = 0;

  conv_pkg::pix_beat_t cur_pix;  // beat on offer until taken.
  conv_pkg::wt_beat_t  cur_wt;

  // pending results, oldest first.
  conv_pkg::result_t exp_data [$];
  conv_pkg::user_t   exp_user [$];
  int                exp_due  [$];

  `include "conv_model.svh"

  conv_engine uut (
    .clk             (clk),
    .rst_n           (rst_n),
    .clken           (clken),
    .s_pixels_valid  (s_pixels_valid),
    .s_pixels        (s_pixels),
    .s_pixels_ready  (s_pixels_ready),
    .s_weights_valid (s_weights_valid),
    .s_weights       (s_weights),
    .s_weights_ready (s_weights_ready),
    .m_valid         (m_valid),
    .m_data          (m_data),
    .m_user          (m_user)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // fresh random pixels and weights for beat_idx.
  task automatic make_beat();
    for (int u = 0; u < conv_pkg::UNITS; u++) begin
      cur_pix.pixels[u] = conv_pkg::pixel_t'($random(seed));
    end
    cur_pix.last = (beat_idx == pkt_len - 1);
    cur_pix.user = conv_pkg::user_t'($random(seed));  // only the last one counts.
    for (int c = 0; c < conv_pkg::CORES; c++) begin
      cur_wt.weights[c] = conv_pkg::weight_t'($random(seed));
    end
  endtask

  task automatic start_packet();
    beat_idx = 0;
    if (pkt_idx >= SINGLE_FROM) begin
      pkt_len = 1;
    end else begin
      pkt_len = 1 + ($random(seed) & 32'hf);  // 1..MAX_BEATS.
    end
    make_beat();
  endtask

  // valids drop independently, clken stalls in bursts after the first phase.
  task automatic drive_controls();
    s_pixels_valid  <= ($random(seed) & 3) != 0;
    s_weights_valid <= ($random(seed) & 3) != 0;
    s_pixels        <= cur_pix;
    s_weights       <= cur_wt;
    if (pkt_idx < HIGH_PKTS) begin
      clken <= 1'b1;
    end else if (stall_left > 0) begin
      clken <= 1'b0;
      stall_left--;
    end else if (($random(seed) & 7) == 0) begin
      clken <= 1'b0;
      stall_left = $random(seed) & 7;  // burst of 1..8 low cycles.
    end else begin
      clken <= 1'b1;
    end
  endtask

  initial begin
    rst_n           = 1'b0;
    clken           = 1'b1;
    s_pixels_valid  = 1'b0;
    s_weights_valid = 1'b0;
    s_pixels        = '0;
    s_weights       = '0;
    clear_sums();
    start_packet();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    while (pkt_idx < NUM_PKTS) begin
      @(posedge clk);
      if (clken && s_pixels_valid && s_weights_valid) begin  // pair taken here.
        if (cur_pix.last) begin
          pkt_idx++;
          if (pkt_idx < NUM_PKTS) start_packet();
        end else begin
          beat_idx++;
          make_beat();
        end
      end
      if (pkt_idx < NUM_PKTS) begin
        drive_controls();
      end else begin
        s_pixels_valid  <= 1'b0;
        s_weights_valid <= 1'b0;
        clken           <= 1'b1;  // let the pipe drain.
      end
    end
    while (exp_due.size() != 0) @(posedge clk);
    repeat (10) @(posedge clk);  // room for a stray duplicate.
    assert (results == NUM_PKTS) else begin
      $display("result count wrong, %0d transfers for %0d packets", results, NUM_PKTS);
      other_errs++;
    end
    $display("checks done: %0d results, %0d value errors, %0d other errors",
             results, value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  // sampled mid cycle, where inputs and outputs are settled.
  always @(negedge clk) begin
    if (rst_n) begin
      assert (s_pixels_ready === join_ready(clken, s_weights_valid)) else begin
        $display("[FAIL] s_pixels_ready got %h expected %h",
                 s_pixels_ready, join_ready(clken, s_weights_valid));
        value_errs++;
      end
      assert (s_weights_ready === join_ready(clken, s_pixels_valid)) else begin
        $display("[FAIL] s_weights_ready got %h expected %h",
                 s_weights_ready, join_ready(clken, s_pixels_valid));
        value_errs++;
      end
      if (clken) begin  // next rising edge is an enabled one.
        if (exp_due.size() != 0 && exp_due[0] == en_cnt) begin
          assert (m_valid === 1'b1) else begin
            $display("[FAIL] m_valid got %h expected 1 at enabled cycle %0d",
                     m_valid, en_cnt);
            value_errs++;
          end
          assert (m_data === exp_data[0]) else begin
            $display("[FAIL] m_data got %h expected %h", m_data, exp_data[0]);
            value_errs++;
          end
          assert (m_user === exp_user[0]) else begin
            $display("[FAIL] m_user got %h expected %h", m_user, exp_user[0]);
            value_errs++;
          end
          if (m_valid === 1'b1) results++;
          void'(exp_data.pop_front());
          void'(exp_user.pop_front());
          void'(exp_due.pop_front());
        end else begin
          assert (m_valid === 1'b0) else begin
            $display("[FAIL] m_valid got %h expected 0 at enabled cycle %0d",
                     m_valid, en_cnt);
            value_errs++;
          end
        end
        if (s_pixels_valid && s_weights_valid) begin
          add_products(s_pixels, s_weights);
          if (s_pixels.last) begin
            exp_data.push_back(pack_sums());
            exp_user.push_back(s_pixels.user);
            exp_due.push_back(en_cnt + RESULT_LAT);
            clear_sums();
          end
        end
        en_cnt++;
      end
    end
  end

endmodule

// File: project.f
+incdir+sim
src/conv_pkg.sv
src/beat_join.sv
src/mul_array.sv
src/acc_array.sv
src/conv_engine.sv
sim/tb_conv_engine.sv
